// ==== flist.f ====
src/icache_pkg.sv
src/icache_ctrl.sv
src/icache_refill.sv
src/icache_store.sv
src/icache_perf.sv
src/icache_top.sv
testbench/axi_mem_model.sv
testbench/tb_icache.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    -f flist.f --top-module tb_icache -o tb_icache_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_icache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation passed$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== testbench/tb_icache.sv ====
`timescale 1ns/1ns

module tb_icache;
    import icache_pkg::*;

    localparam int          period        = 40;
    localparam logic [31:0] pattern       = 32'hA5C3_5A3C;
    localparam logic [31:0] err_base      = 32'h0000_8000;
    localparam logic [31:0] err_limit     = 32'h0000_80FF;
    localparam logic [1:0]  resp_slverr   = 2'b10;
    localparam int          max_latency   = 8;
    localparam int          max_stall     = 4;
    // reads issued by all tests together
    localparam int          total_fetches = 49;
    localparam int          read_limit    = 40;

    logic        clk;
    logic        rst_n;
    logic        flush;
    axi_ar_t     core_ar;
    axi_ar_t     bus_ar;
    axi_r_t      core_r;
    axi_r_t      bus_r;
    logic        core_arvalid;
    logic        core_arready;
    logic        core_rvalid;
    logic        core_rready;
    logic        bus_arvalid;
    logic        bus_arready;
    logic        bus_rvalid;
    logic        bus_rready;
    logic [31:0] hit_count;
    logic [31:0] miss_count;
    logic [31:0] miss_cycles;

    int          cycle = 0;
    int          errors = 0;
    int          exp_hits = 0;
    int          exp_misses = 0;
    logic [31:0] last_miss_cycles = '0;
    string       test_name;
    logic        model_valid [16];
    logic [25:0] model_tag [16];

    icache_top #(.count_width(32)) uut (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .core_ar(core_ar), .core_arvalid(core_arvalid), .core_arready(core_arready),
        .core_r(core_r), .core_rvalid(core_rvalid), .core_rready(core_rready),
        .bus_ar(bus_ar), .bus_arvalid(bus_arvalid), .bus_arready(bus_arready),
        .bus_r(bus_r), .bus_rvalid(bus_rvalid), .bus_rready(bus_rready),
        .hit_count(hit_count), .miss_count(miss_count), .miss_cycles(miss_cycles)
    );

    axi_mem_model #(
        .pattern(pattern), .err_base(err_base), .err_limit(err_limit),
        .max_latency(max_latency)
    ) u_mem (
        .clk(clk), .rst_n(rst_n),
        .bus_ar(bus_ar), .bus_arvalid(bus_arvalid), .bus_arready(bus_arready),
        .bus_r(bus_r), .bus_rvalid(bus_rvalid), .bus_rready(bus_rready)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(period / 2) clk = ~clk;
        end
    end

    always @(posedge clk) cycle <= cycle + 1;

    initial begin
        #((total_fetches * (2 + max_latency + max_stall + 8) + 20) * period);
        $display("watchdog expired before the tests finished");
        $display("Simulation failed");
        $finish;
    end

    task automatic check_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            errors++;
            $display("CHECK FAILED %s: %s expected %h actual %h",
                     test_name, what, expected, actual);
        end
    endtask

    task automatic core_read(input logic [31:0] addr, input int stall,
                             output logic [31:0] data, output logic [1:0] resp,
                             output int latency, output bit done);
        int accept_cycle;
        int waited;
        done = 1'b0;
        latency = 0;
        @(posedge clk);
        #5;
        core_ar.addr = addr;
        core_arvalid = 1'b1;
        waited = 0;
        while (!core_arready && waited < read_limit) begin
            @(posedge clk);
            #5;
            waited++;
        end
        if (!core_arready) begin
            errors++;
            $display("%s: fetch of address %h was never accepted", test_name, addr);
            core_arvalid = 1'b0;
            return;
        end
        accept_cycle = cycle;
        @(posedge clk);
        #5;
        core_arvalid = 1'b0;
        waited = 0;
        while (!core_rvalid && waited < read_limit) begin
            @(posedge clk);
            #5;
            waited++;
        end
        if (!core_rvalid) begin
            errors++;
            $display("%s: no read response for address %h", test_name, addr);
            return;
        end
        latency = cycle - accept_cycle;
        data = core_r.data;
        resp = core_r.resp;
        repeat (stall) begin
            @(posedge clk);
            #5;
            check_equal("rvalid held", 1, core_rvalid);
            check_equal("data held", data, core_r.data);
            check_equal("resp held", resp, core_r.resp);
            check_equal("arready during stall", 0, core_arready);
        end
        core_rready = 1'b1;
        @(posedge clk);
        #5;
        core_rready = 1'b0;
        check_equal("arready after return", 1, core_arready);
        done = 1'b1;
    endtask

    // predicts hit or miss from the local valid/tag copy and checks the result
    task automatic checked_read(input logic [31:0] addr, input int stall);
        logic [31:0] data;
        logic [1:0]  resp;
        int          latency;
        bit          done;
        bit          predict_hit;
        bit          is_error;
        logic [3:0]  index;
        logic [25:0] tag;
        index = addr[5:2];
        tag = addr[31:6];
        predict_hit = model_valid[index] && (model_tag[index] == tag);
        is_error = (addr >= err_base) && (addr <= err_limit);
        core_read(addr, stall, data, resp, latency, done);
        if (!done) begin
            return;
        end
        if (predict_hit) begin
            exp_hits++;
        end else begin
            exp_misses++;
        end
        if (!predict_hit && !is_error) begin
            model_valid[index] = 1'b1;
            model_tag[index] = tag;
        end
        check_equal("read data", {addr[31:2], 2'b00} ^ pattern, data);
        check_equal("read resp", is_error ? resp_slverr : resp_okay, resp);
        check_equal("hit_count", exp_hits, hit_count);
        check_equal("miss_count", exp_misses, miss_count);
        if (predict_hit) begin
            check_equal("hit latency", 2, latency);
            check_equal("miss_cycles on hit", last_miss_cycles, miss_cycles);
        end else begin
            assert (miss_cycles >= last_miss_cycles + 3) else begin
                errors++;
                $display("CHECK FAILED %s: miss_cycles expected >= %0d actual %0d",
                         test_name, last_miss_cycles + 3, miss_cycles);
            end
        end
        last_miss_cycles = miss_cycles;
    endtask

    task automatic pulse_flush();
        @(posedge clk);
        #5;
        flush = 1'b1;
        @(posedge clk);
        #5;
        flush = 1'b0;
        for (int i = 0; i < 16; i++) begin
            model_valid[i] = 1'b0;
        end
    endtask

    task automatic cold_miss_then_hit();
        test_name = "cold_miss_then_hit";
        checked_read(32'h0000_1040, 0);
        checked_read(32'h0000_1040, 0);
    endtask

    task automatic conflict_eviction();
        int base;
        test_name = "conflict_eviction";
        checked_read(32'h0000_1048, 0);
        checked_read(32'h0000_104C, 0);
        base = exp_misses;
        // two tags share index 1
        repeat (3) begin
            checked_read(32'h0000_2004, 0);
            checked_read(32'h0000_3004, 0);
            checked_read(32'h0000_1048, 0);
            checked_read(32'h0000_104C, 0);
        end
        check_equal("misses in conflict loop", base + 6, miss_count);
    endtask

    task automatic error_not_cached();
        int base;
        test_name = "error_not_cached";
        base = exp_misses;
        checked_read(32'h0000_8010, 0);
        checked_read(32'h0000_8010, 0);
        check_equal("misses on repeated error read", base + 2, miss_count);
    endtask

    task automatic flush_lines();
        int base;
        test_name = "flush_lines";
        for (int i = 0; i < 4; i++) begin
            checked_read(32'h0000_5000 + i * 4, 0);
        end
        pulse_flush();
        base = exp_misses;
        for (int i = 0; i < 8; i++) begin
            checked_read(32'h0000_5000 + (i % 4) * 4, 0);
        end
        check_equal("misses after flush", base + 4, miss_count);
    endtask

    task automatic core_backpressure();
        test_name = "core_backpressure";
        checked_read(32'h0000_6010, 3);
        checked_read(32'h0000_6010, max_stall);
        checked_read(32'h0000_6014, 2);
    endtask

    task automatic miss_penalty();
        logic [31:0] base;
        test_name = "miss_penalty";
        for (int i = 0; i < 8; i++) begin
            checked_read(32'h0000_7000 + i * 4, i % 3);
        end
        assert (miss_cycles >= 3 * exp_misses) else begin
            errors++;
            $display("CHECK FAILED %s: miss_cycles expected >= %0d actual %0d",
                     test_name, 3 * exp_misses, miss_cycles);
        end
        base = miss_cycles;
        for (int i = 0; i < 8; i++) begin
            checked_read(32'h0000_7000 + i * 4, 0);
        end
        check_equal("miss_cycles over hits", base, miss_cycles);
    endtask

    initial begin
        rst_n = 1'b0;
        flush = 1'b0;
        core_ar = '0;
        core_arvalid = 1'b0;
        core_rready = 1'b0;
        for (int i = 0; i < 16; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i] = '0;
        end
        repeat (2) @(posedge clk);
        #5;
        rst_n = 1'b1;
        cold_miss_then_hit();
        conflict_eviction();
        error_not_cached();
        flush_lines();
        core_backpressure();
        miss_penalty();
        $display("tests finished with %0d errors", errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== testbench/axi_mem_model.sv ====
`timescale 1ns/1ns

module axi_mem_model #(
    parameter logic [31:0] pattern     = 32'hA5C3_5A3C,
    parameter logic [31:0] err_base    = 32'h0000_8000,
    parameter logic [31:0] err_limit   = 32'h0000_80FF,
    parameter int          max_latency = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  icache_pkg::axi_ar_t bus_ar,
    input  logic                bus_arvalid,
    output logic                bus_arready,
    output icache_pkg::axi_r_t  bus_r,
    output logic                bus_rvalid,
    input  logic                bus_rready
);
    import icache_pkg::*;

    localparam logic [1:0] resp_slverr = 2'b10;

    integer seed;
    logic   busy;
    int     delay;

    initial seed = 67;

    // one read at a time
    assign bus_arready = !busy && !bus_rvalid;

    always @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            bus_rvalid <= 1'b0;
            delay      <= 0;
            bus_r      <= '0;
        end else if (bus_arvalid && bus_arready) begin
            busy       <= 1'b1;
            delay      <= 1 + ({$random(seed)} % max_latency);
            bus_r.data <= bus_ar.addr ^ pattern;
            bus_r.resp <= (bus_ar.addr >= err_base && bus_ar.addr <= err_limit) ?
                          resp_slverr : resp_okay;
        end else if (busy) begin
            if (delay <= 1) begin
                busy       <= 1'b0;
                bus_rvalid <= 1'b1;
            end else begin
                delay <= delay - 1;
            end
        end else if (bus_rvalid && bus_rready) begin
            bus_rvalid <= 1'b0;
        end
    end

endmodule

// ==== src/icache_top.sv ====
`timescale 1ns/1ns

module icache_top #(
    parameter int count_width = 32
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   flush,

    // core side
    input  icache_pkg::axi_ar_t    core_ar,
    input  logic                   core_arvalid,
    output logic                   core_arready,
    output icache_pkg::axi_r_t     core_r,
    output logic                   core_rvalid,
    input  logic                   core_rready,

    // bus side
    output icache_pkg::axi_ar_t    bus_ar,
    output logic                   bus_arvalid,
    input  logic                   bus_arready,
    input  icache_pkg::axi_r_t     bus_r,
    input  logic                   bus_rvalid,
    output logic                   bus_rready,

    output logic [count_width-1:0] hit_count,
    output logic [count_width-1:0] miss_count,
    output logic [count_width-1:0] miss_cycles
);
    import icache_pkg::*;

    fetch_addr_u           lookup_addr;
    logic                  hit;
    logic [addr_width-1:0] hit_data;
    logic                  fill_en;
    logic [addr_width-1:0] fill_data;
    logic                  refill_start;
    logic                  refill_done;
    refill_rsp_t           refill_rsp;
    logic                  hit_event;
    logic                  miss_event;
    logic                  miss_busy;

    icache_ctrl u_ctrl (
        .clk(clk), .rst_n(rst_n),
        .core_ar(core_ar), .core_arvalid(core_arvalid), .core_arready(core_arready),
        .core_r(core_r), .core_rvalid(core_rvalid), .core_rready(core_rready),
        .lookup_addr(lookup_addr), .hit(hit), .hit_data(hit_data),
        .refill_start(refill_start), .refill_done(refill_done), .refill_rsp(refill_rsp),
        .hit_event(hit_event), .miss_event(miss_event), .miss_busy(miss_busy)
    );

    icache_refill u_refill (
        .clk(clk), .rst_n(rst_n),
        .refill_start(refill_start), .lookup_addr(lookup_addr),
        .bus_ar(bus_ar), .bus_arvalid(bus_arvalid), .bus_arready(bus_arready),
        .bus_r(bus_r), .bus_rvalid(bus_rvalid), .bus_rready(bus_rready),
        .refill_done(refill_done), .refill_rsp(refill_rsp),
        .fill_en(fill_en), .fill_data(fill_data)
    );

    icache_store u_store (
        .clk(clk), .rst_n(rst_n), .flush(flush),
        .lookup_addr(lookup_addr), .fill_en(fill_en), .fill_data(fill_data),
        .hit(hit), .hit_data(hit_data)
    );

    icache_perf #(
        .count_width(count_width)
    ) u_perf (
        .clk(clk), .rst_n(rst_n),
        .hit_event(hit_event), .miss_event(miss_event), .miss_busy(miss_busy),
        .hit_count(hit_count), .miss_count(miss_count), .miss_cycles(miss_cycles)
    );

endmodule

// ==== src/icache_perf.sv ====
`timescale 1ns/1ns

module icache_perf #(
    parameter int count_width = 32
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   hit_event,
    input  logic                   miss_event,
    input  logic                   miss_busy,
    output logic [count_width-1:0] hit_count,
    output logic [count_width-1:0] miss_count,
    output logic [count_width-1:0] miss_cycles
);

    // stop at all ones instead of wrapping
    function automatic logic [count_width-1:0] sat_inc(
        input logic [count_width-1:0] value
    );
        if (&value) begin
            return value;
        end
        return value + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hit_count   <= '0;
            miss_count  <= '0;
            miss_cycles <= '0;
        end else begin
            if (hit_event) begin
                hit_count <= sat_inc(hit_count);
            end
            if (miss_event) begin
                miss_count <= sat_inc(miss_count);
            end
            if (miss_busy) begin
                miss_cycles <= sat_inc(miss_cycles);
            end
        end
    end

endmodule

// ==== src/icache_store.sv ====
`timescale 1ns/1ns

module icache_store (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              flush,
    input  icache_pkg::fetch_addr_u           lookup_addr,
    input  logic                              fill_en,
    input  logic [icache_pkg::addr_width-1:0] fill_data,
    output logic                              hit,
    output logic [icache_pkg::addr_width-1:0] hit_data
);
    import icache_pkg::*;

    localparam int line_count = 1 << index_bits;

    logic [addr_width-1:0] data_mem [line_count];
    logic [tag_bits-1:0]   tag_mem  [line_count];
    logic [line_count-1:0] valid_q;

    logic [index_bits-1:0] index;
    logic [tag_bits-1:0]   tag;

    // field view of the same fetch word
    assign index = lookup_addr.fields.index;
    assign tag   = lookup_addr.fields.tag;

    assign hit      = valid_q[index] && (tag_mem[index] == tag);
    assign hit_data = data_mem[index];

    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_mem[index] <= fill_data;
            tag_mem[index]  <= tag;
        end
    end

    // flush wins over a fill in the same cycle
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (flush) begin
            valid_q <= '0;
        end else if (fill_en) begin
            valid_q[index] <= 1'b1;
        end
    end

    // refill only ever runs for a line that missed
    no_fill_on_hit: assert property (@(posedge clk) disable iff (!rst_n)
        !(fill_en && hit));

endmodule

// ==== src/icache_refill.sv ====
`timescale 1ns/1ns

module icache_refill (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              refill_start,
    input  icache_pkg::fetch_addr_u           lookup_addr,
    output icache_pkg::axi_ar_t               bus_ar,
    output logic                              bus_arvalid,
    input  logic                              bus_arready,
    input  icache_pkg::axi_r_t                bus_r,
    input  logic                              bus_rvalid,
    output logic                              bus_rready,
    output logic                              refill_done,
    output icache_pkg::refill_rsp_t           refill_rsp,
    output logic                              fill_en,
    output logic [icache_pkg::addr_width-1:0] fill_data
);
    import icache_pkg::*;

    localparam logic [1:0] st_idle = 2'd0;
    localparam logic [1:0] st_addr = 2'd1;
    localparam logic [1:0] st_wait = 2'd2;
    localparam logic [1:0] st_done = 2'd3;

    logic [1:0]  state;
    axi_ar_t     ar_q;
    refill_rsp_t rsp_q;

    assign bus_ar      = ar_q;
    assign bus_arvalid = (state == st_addr);
    assign bus_rready  = (state == st_wait);
    assign refill_done = (state == st_done);
    assign refill_rsp  = rsp_q;
    assign fill_data   = rsp_q.data;

    // bus errors never reach the arrays
    assign fill_en = refill_done && (rsp_q.resp == resp_okay);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (refill_start) begin
                        state <= st_addr;
                    end
                end
                st_addr: begin
                    if (bus_arready) begin
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    if (bus_rvalid) begin
                        state <= st_done;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (refill_start && state == st_idle) begin
            // word aligned, the offset bits are dropped
            ar_q.addr <= {lookup_addr.fields.tag, lookup_addr.fields.index,
                          {offset_bits{1'b0}}};
        end
        if (bus_rvalid && bus_rready) begin
            rsp_q.data <= bus_r.data;
            rsp_q.resp <= bus_r.resp;
        end
    end

    arvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
        bus_arvalid && !bus_arready |=> bus_arvalid && $stable(bus_ar));

endmodule

// ==== src/icache_ctrl.sv ====
`timescale 1ns/1ns

module icache_ctrl (
    input  logic                              clk,
    input  logic                              rst_n,
    input  icache_pkg::axi_ar_t               core_ar,
    input  logic                              core_arvalid,
    output logic                              core_arready,
    output icache_pkg::axi_r_t                core_r,
    output logic                              core_rvalid,
    input  logic                              core_rready,
    output icache_pkg::fetch_addr_u           lookup_addr,
    input  logic                              hit,
    input  logic [icache_pkg::addr_width-1:0] hit_data,
    output logic                              refill_start,
    input  logic                              refill_done,
    input  icache_pkg::refill_rsp_t           refill_rsp,
    output logic                              hit_event,
    output logic                              miss_event,
    output logic                              miss_busy
);
    import icache_pkg::*;

    localparam logic [1:0] st_idle      = 2'd0;
    localparam logic [1:0] st_lookup    = 2'd1;
    localparam logic [1:0] st_miss_wait = 2'd2;
    localparam logic [1:0] st_return    = 2'd3;

    logic [1:0]  state;
    fetch_addr_u addr_q;
    axi_r_t      r_q;

    assign core_arready = (state == st_idle);
    assign core_rvalid  = (state == st_return);
    assign core_r       = r_q;
    assign lookup_addr  = addr_q;

    // lookup lasts exactly one cycle, so these are single pulses
    assign hit_event    = (state == st_lookup) && hit;
    assign miss_event   = (state == st_lookup) && !hit;
    assign refill_start = miss_event;
    assign miss_busy    = (state == st_miss_wait);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (core_arvalid) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    state <= hit ? st_return : st_miss_wait;
                end
                st_miss_wait: begin
                    if (refill_done) begin
                        state <= st_return;
                    end
                end
                st_return: begin
                    if (core_rready) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (core_arvalid && core_arready) begin
            addr_q.word <= core_ar.addr;
        end
        if (hit_event) begin
            r_q.data <= hit_data;
            r_q.resp <= resp_okay;
        end else if (miss_busy && refill_done) begin
            // error responses go straight through to the core
            r_q.data <= refill_rsp.data;
            r_q.resp <= refill_rsp.resp;
        end
    end

    rvalid_held: assert property (@(posedge clk) disable iff (!rst_n)
        core_rvalid && !core_rready |=> core_rvalid && $stable(core_r));

endmodule

// ==== src/icache_pkg.sv ====
package icache_pkg;

    // address split, direct mapped with one word per line
    parameter int addr_width  = 32;
    parameter int offset_bits = 2;
    parameter int index_bits  = 4;
    parameter int tag_bits    = addr_width - index_bits - offset_bits;
    parameter int resp_bits   = 2;

    parameter logic [resp_bits-1:0] resp_okay = 2'b00;

    typedef struct packed {
        logic [tag_bits-1:0]    tag;
        logic [index_bits-1:0]  index;
        logic [offset_bits-1:0] offset;
    } addr_fields_t;

    // ctrl keeps the flat word, store reads the fields
    typedef union packed {
        logic [addr_width-1:0] word;
        addr_fields_t          fields;
    } fetch_addr_u;

    // axi-lite read address channel payload
    typedef struct packed {
        logic [addr_width-1:0] addr;
    } axi_ar_t;

    // axi-lite read data channel payload
    typedef struct packed {
        logic [addr_width-1:0] data;
        logic [resp_bits-1:0]  resp;
    } axi_r_t;

    // result handed from the refill engine to ctrl
    typedef struct packed {
        logic [addr_width-1:0] data;
        logic [resp_bits-1:0]  resp;
    } refill_rsp_t;

endpackage
